// File: files.f
source/ex_pkg.sv
source/div_if.sv
source/div_iter_counter.sv
source/div_unit.sv
source/alu_core.sv
source/hilo_regs.sv
source/ex_ctrl_fsm.sv
source/ex_top.sv
verification/ex_assertions.sv
verification/ex_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the ex_top testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module ex_tb -f files.f \
    -o ex_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/ex_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: source/alu_core.sv
module alu_core #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  ex_pkg::aluop_t        aluop_i,
    input  logic [DATA_W-1:0]     reg1_i,
    input  logic [DATA_W-1:0]     reg2_i,
    input  logic [DATA_W-1:0]     hi_i,
    input  logic [DATA_W-1:0]     lo_i,
    output logic [DATA_W-1:0]     wdata_o,
    output logic [2*DATA_W-1:0]   product_o,
    output ex_pkg::hilo_op_t      hilo_op_o
);
    import ex_pkg::*;

    localparam int SH_W = index_width(DATA_W);
    localparam int LZ_W = count_width(DATA_W);

    logic [SH_W-1:0]     shamt;
    logic [DATA_W-1:0]   lead_src;
    logic [LZ_W-1:0]     lead_cnt;
    logic                mul_signed;
    logic                prod_neg;
    logic [DATA_W-1:0]   mul_a;
    logic [DATA_W-1:0]   mul_b;
    logic [2*DATA_W-1:0] mag_prod;
    logic [2*DATA_W-1:0] signed_prod;

    assign shamt = reg1_i[SH_W-1:0];

    // clo is clz of the inverted operand
    assign lead_src = (aluop_i == OP_CLO) ? ~reg1_i : reg1_i;

    always_comb begin
        lead_cnt = LZ_W'(DATA_W);
        for (int i = 0; i < DATA_W; i++) begin
            if (lead_src[i]) begin
                lead_cnt = LZ_W'(DATA_W - 1 - i);
            end
        end
    end

    // multiply magnitudes, then put the sign back
    assign mul_signed  = is_signed_op(aluop_i);
    assign mul_a       = (mul_signed && reg1_i[DATA_W-1]) ? (~reg1_i + 1'b1) : reg1_i;
    assign mul_b       = (mul_signed && reg2_i[DATA_W-1]) ? (~reg2_i + 1'b1) : reg2_i;
    assign mag_prod    = mul_a * mul_b;
    assign prod_neg    = mul_signed && (reg1_i[DATA_W-1] ^ reg2_i[DATA_W-1]);
    assign signed_prod = prod_neg ? (~mag_prod + 1'b1) : mag_prod;
    assign product_o   = (hilo_op_o == ACC_SUB) ? (~signed_prod + 1'b1) : signed_prod;

    always_comb begin
        case (aluop_i)
            OP_OR:   wdata_o = reg1_i | reg2_i;
            OP_AND:  wdata_o = reg1_i & reg2_i;
            OP_XOR:  wdata_o = reg1_i ^ reg2_i;
            OP_NOR:  wdata_o = ~(reg1_i | reg2_i);
            OP_SLL:  wdata_o = reg2_i << shamt;
            OP_SRL:  wdata_o = reg2_i >> shamt;
            OP_SRA:  wdata_o = $unsigned($signed(reg2_i) >>> shamt);
            OP_ADDU: wdata_o = reg1_i + reg2_i;
            OP_SUBU: wdata_o = reg1_i - reg2_i;
            OP_SLT:  wdata_o = DATA_W'($signed(reg1_i) < $signed(reg2_i));
            OP_SLTU: wdata_o = DATA_W'(reg1_i < reg2_i);
            OP_CLZ,
            OP_CLO:  wdata_o = DATA_W'(lead_cnt);
            OP_MFHI: wdata_o = hi_i;
            OP_MFLO: wdata_o = lo_i;
            OP_MUL:  wdata_o = signed_prod[DATA_W-1:0];
            default: wdata_o = '0;
        endcase
    end

    always_comb begin
        if (is_mac_op(aluop_i)) begin
            hilo_op_o = (aluop_i inside {OP_MSUB, OP_MSUBU}) ? ACC_SUB : ACC_ADD;
        end else if (is_div_op(aluop_i)) begin
            hilo_op_o = LOAD_BOTH;
        end else begin
            case (aluop_i)
                OP_MULT,
                OP_MULTU: hilo_op_o = LOAD_BOTH;
                OP_MTHI:  hilo_op_o = LOAD_HI;
                OP_MTLO:  hilo_op_o = LOAD_LO;
                default:  hilo_op_o = NONE;
            endcase
        end
    end
endmodule

// File: source/div_if.sv
interface div_if #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
);
    logic              start;
    logic              is_signed;
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
    logic              done;
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;

    modport seq (
        output start, is_signed, dividend, divisor,
        input  done, quotient, remainder
    );

    modport divider (
        input  start, is_signed, dividend, divisor,
        output done, quotient, remainder
    );
endinterface

// File: source/div_iter_counter.sv
module div_iter_counter #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic clear_i,
    input  logic step_en_i,
    output logic last_step_o
);
    import ex_pkg::*;

    localparam int CNT_W = index_width(DATA_W);

    logic [CNT_W-1:0] cnt_q;

    // count holds the number of steps already taken
    assign last_step_o = step_en_i && (cnt_q == CNT_W'(DATA_W - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (step_en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end
endmodule

// File: source/div_unit.sv
module div_unit #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic   clk,
    input  logic   rst_n_i,
    div_if.divider div
);
    logic              running_q;
    logic              step_en;
    logic              last_step;
    logic              dvd_neg;
    logic              dvs_neg;
    logic [DATA_W-1:0] dvd_mag;
    logic [DATA_W-1:0] dvs_mag;
    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] quo_q;
    logic [DATA_W-1:0] dvs_q;
    logic              neg_quo_q;
    logic              neg_rem_q;
    logic [DATA_W-1:0] src_rem;
    logic [DATA_W-1:0] src_quo;
    logic [DATA_W-1:0] src_dvs;
    logic [DATA_W:0]   shifted;
    logic [DATA_W:0]   trial;

    div_iter_counter #(
        .DATA_W (DATA_W)
    ) u_cnt (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .clear_i     (last_step),
        .step_en_i   (step_en),
        .last_step_o (last_step)
    );

    assign dvd_neg = div.is_signed && div.dividend[DATA_W-1];
    assign dvs_neg = div.is_signed && div.divisor[DATA_W-1];
    assign dvd_mag = dvd_neg ? (~div.dividend + 1'b1) : div.dividend;
    assign dvs_mag = dvs_neg ? (~div.divisor + 1'b1) : div.divisor;

    // first step is taken on the start edge straight from the operands
    assign step_en = div.start || running_q;
    assign src_rem = div.start ? '0 : rem_q;
    assign src_quo = div.start ? dvd_mag : quo_q;
    assign src_dvs = div.start ? dvs_mag : dvs_q;

    assign shifted = {src_rem, src_quo[DATA_W-1]};
    assign trial   = shifted - {1'b0, src_dvs};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            running_q <= 1'b0;
        end else begin
            running_q <= step_en && !last_step;
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            // restore by keeping the shifted value when the trial goes negative
            rem_q <= trial[DATA_W] ? shifted[DATA_W-1:0] : trial[DATA_W-1:0];
            quo_q <= {src_quo[DATA_W-2:0], ~trial[DATA_W]};
        end
        if (div.start) begin
            dvs_q     <= dvs_mag;
            neg_quo_q <= dvd_neg ^ dvs_neg;
            neg_rem_q <= dvd_neg;
        end
    end

    // zero divisor falls out as all-ones quotient and dividend remainder
    assign div.done      = last_step;
    assign div.quotient  = neg_quo_q ? (~quo_q + 1'b1) : quo_q;
    assign div.remainder = neg_rem_q ? (~rem_q + 1'b1) : rem_q;
endmodule

// File: source/ex_ctrl_fsm.sv
module ex_ctrl_fsm #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  op_valid_i,
    input  ex_pkg::aluop_t        aluop_i,
    input  logic [DATA_W-1:0]     reg1_i,
    input  logic [DATA_W-1:0]     reg2_i,
    input  logic [DATA_W-1:0]     wdata_i,
    input  logic [2*DATA_W-1:0]   product_i,
    input  ex_pkg::hilo_op_t      hilo_op_i,
    div_if.seq                    div,
    output logic                  hilo_we_o,
    output ex_pkg::hilo_op_t      hilo_op_o,
    output logic [2*DATA_W-1:0]   hilo_data_o,
    output logic                  busy_o,
    output logic                  result_valid_o,
    output logic [DATA_W-1:0]     wdata_o
);
    import ex_pkg::*;

    ex_state_t           state_q;
    logic                accept;
    logic [2*DATA_W-1:0] prod_q;
    hilo_op_t            acc_op_q;

    assign accept = (state_q == IDLE) && op_valid_i;
    assign busy_o = (state_q != IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q        <= IDLE;
            result_valid_o <= 1'b0;
            div.start      <= 1'b0;
        end else begin
            result_valid_o <= 1'b0;
            div.start      <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (op_valid_i) begin
                        if (is_mac_op(aluop_i)) begin
                            state_q <= MAC_ACC;
                        end else if (is_div_op(aluop_i)) begin
                            state_q   <= DIV_RUN;
                            div.start <= 1'b1;
                        end else begin
                            result_valid_o <= 1'b1;
                        end
                    end
                end
                MAC_ACC: begin
                    state_q        <= IDLE;
                    result_valid_o <= 1'b1;
                end
                // done marks the final step, result is settled one edge later
                DIV_RUN: begin
                    if (div.done) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: begin
                    state_q        <= IDLE;
                    result_valid_o <= 1'b1;
                end
            endcase
        end
    end

    // operands captured when an operation is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            wdata_o       <= wdata_i;
            prod_q        <= product_i;
            acc_op_q      <= hilo_op_i;
            div.dividend  <= reg1_i;
            div.divisor   <= reg2_i;
            div.is_signed <= is_signed_op(aluop_i);
        end
    end

    always_comb begin
        hilo_we_o   = 1'b0;
        hilo_op_o   = NONE;
        hilo_data_o = product_i;
        case (state_q)
            IDLE: begin
                if (op_valid_i && !is_mac_op(aluop_i) && !is_div_op(aluop_i)) begin
                    hilo_we_o = (hilo_op_i != NONE);
                    hilo_op_o = hilo_op_i;
                    if (hilo_op_i == LOAD_HI || hilo_op_i == LOAD_LO) begin
                        hilo_data_o = {reg1_i, reg1_i};
                    end
                end
            end
            MAC_ACC: begin
                hilo_we_o   = 1'b1;
                hilo_op_o   = acc_op_q;
                hilo_data_o = prod_q;
            end
            DIV_DONE: begin
                hilo_we_o   = 1'b1;
                hilo_op_o   = LOAD_BOTH;
                hilo_data_o = {div.remainder, div.quotient};
            end
            default: begin
                hilo_we_o = 1'b0;
            end
        endcase
    end
endmodule

// File: source/ex_pkg.sv
package ex_pkg;

    localparam int DATA_W_DEFAULT = 32;

    // encodings are fixed, the test vectors use them as numbers
    typedef enum logic [4:0] {
        OP_OR    = 5'd0,
        OP_AND   = 5'd1,
        OP_XOR   = 5'd2,
        OP_NOR   = 5'd3,
        OP_SLL   = 5'd4,
        OP_SRL   = 5'd5,
        OP_SRA   = 5'd6,
        OP_ADDU  = 5'd7,
        OP_SUBU  = 5'd8,
        OP_SLT   = 5'd9,
        OP_SLTU  = 5'd10,
        OP_CLZ   = 5'd11,
        OP_CLO   = 5'd12,
        OP_MFHI  = 5'd13,
        OP_MFLO  = 5'd14,
        OP_MTHI  = 5'd15,
        OP_MTLO  = 5'd16,
        OP_MUL   = 5'd17,
        OP_MULT  = 5'd18,
        OP_MULTU = 5'd19,
        OP_MADD  = 5'd20,
        OP_MADDU = 5'd21,
        OP_MSUB  = 5'd22,
        OP_MSUBU = 5'd23,
        OP_DIV   = 5'd24,
        OP_DIVU  = 5'd25
    } aluop_t;

    typedef enum logic [1:0] {
        IDLE,
        MAC_ACC,
        DIV_RUN,
        DIV_DONE
    } ex_state_t;

    typedef enum logic [2:0] {
        NONE,
        LOAD_BOTH,
        LOAD_HI,
        LOAD_LO,
        ACC_ADD,
        ACC_SUB
    } hilo_op_t;

    function automatic logic is_mac_op(aluop_t op);
        return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    function automatic logic is_div_op(aluop_t op);
        return op inside {OP_DIV, OP_DIVU};
    endfunction

    function automatic logic is_signed_op(aluop_t op);
        return op inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB, OP_DIV};
    endfunction

    // bits for values 0 .. n-1
    function automatic int index_width(int n);
        return (n > 2) ? $clog2(n) : 1;
    endfunction

    // bits for values 0 .. n
    function automatic int count_width(int n);
        return index_width(n + 1);
    endfunction

endpackage

// File: source/ex_top.sv
module ex_top #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              op_valid_i,
    input  ex_pkg::aluop_t    aluop_i,
    input  logic [DATA_W-1:0] reg1_i,
    input  logic [DATA_W-1:0] reg2_i,
    output logic              busy_o,
    output logic              result_valid_o,
    output logic [DATA_W-1:0] wdata_o,
    output logic [DATA_W-1:0] hi_o,
    output logic [DATA_W-1:0] lo_o
);
    import ex_pkg::*;

    logic [DATA_W-1:0]   alu_wdata;
    logic [2*DATA_W-1:0] alu_product;
    hilo_op_t            alu_hilo_op;
    logic                hilo_we;
    hilo_op_t            hilo_op;
    logic [2*DATA_W-1:0] hilo_data;

    div_if #(.DATA_W(DATA_W)) div_bus ();

    alu_core #(
        .DATA_W (DATA_W)
    ) u_alu (
        .aluop_i   (aluop_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .hi_i      (hi_o),
        .lo_i      (lo_o),
        .wdata_o   (alu_wdata),
        .product_o (alu_product),
        .hilo_op_o (alu_hilo_op)
    );

    ex_ctrl_fsm #(
        .DATA_W (DATA_W)
    ) u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .op_valid_i     (op_valid_i),
        .aluop_i        (aluop_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .wdata_i        (alu_wdata),
        .product_i      (alu_product),
        .hilo_op_i      (alu_hilo_op),
        .div            (div_bus.seq),
        .hilo_we_o      (hilo_we),
        .hilo_op_o      (hilo_op),
        .hilo_data_o    (hilo_data),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .wdata_o        (wdata_o)
    );

    div_unit #(
        .DATA_W (DATA_W)
    ) u_div (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .div     (div_bus.divider)
    );

    hilo_regs #(
        .DATA_W (DATA_W)
    ) u_hilo (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .we_i      (hilo_we),
        .hilo_op_i (hilo_op),
        .data_i    (hilo_data),
        .hi_o      (hi_o),
        .lo_o      (lo_o)
    );
endmodule

// File: source/hilo_regs.sv
module hilo_regs #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  ex_pkg::hilo_op_t    hilo_op_i,
    input  logic [2*DATA_W-1:0] data_i,
    output logic [DATA_W-1:0]   hi_o,
    output logic [DATA_W-1:0]   lo_o
);
    import ex_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (we_i) begin
            case (hilo_op_i)
                LOAD_BOTH: begin
                    {hi_o, lo_o} <= data_i;
                end
                LOAD_HI: begin
                    hi_o <= data_i[2*DATA_W-1:DATA_W];
                end
                LOAD_LO: begin
                    lo_o <= data_i[DATA_W-1:0];
                end
                // msub arrives with the product already negated
                ACC_ADD,
                ACC_SUB: begin
                    {hi_o, lo_o} <= {hi_o, lo_o} + data_i;
                end
                default: begin
                    hi_o <= hi_o;
                end
            endcase
        end
    end
endmodule

// File: verification/ex_assertions.sv
module ex_assertions #(
    parameter int DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input logic              clk,
    input logic              rst_n_i,
    input logic              op_valid_i,
    input logic              busy_i,
    input logic              result_valid_i,
    input ex_pkg::ex_state_t state_i,
    input logic              div_start_i,
    input logic              div_done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import ex_pkg::*;

    int unsigned idle_fail_cnt = 0;
    int unsigned div_fail_cnt  = 0;
    int unsigned busy_fail_cnt = 0;
    logic        div_pending_q;
    int unsigned div_wait_q;

    // cycles since the last divider start
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            div_pending_q <= 1'b0;
            div_wait_q    <= 0;
        end else if (div_start_i) begin
            div_pending_q <= 1'b1;
            div_wait_q    <= 1;
        end else if (div_done_i) begin
            div_pending_q <= 1'b0;
            div_wait_q    <= 0;
        end else if (div_pending_q) begin
            div_wait_q <= div_wait_q + 1;
        end
    end

    idle_result_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_i != IDLE) |-> !result_valid_i)
        else begin
            idle_fail_cnt = idle_fail_cnt + 1;
            $error("result_valid_o high while the sequencer is mid-operation");
        end

    div_done_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(div_pending_q && div_wait_q > DATA_W + 2))
        else begin
            div_fail_cnt = div_fail_cnt + 1;
            $error("divider done missing %0d cycles after start", DATA_W + 2);
        end

    busy_rise_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(busy_i) |-> $past(op_valid_i))
        else begin
            busy_fail_cnt = busy_fail_cnt + 1;
            $error("busy_o rose without op_valid_i in the previous cycle");
        end
endmodule

bind ex_top ex_assertions #(
    .DATA_W (DATA_W)
) u_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .op_valid_i     (op_valid_i),
    .busy_i         (busy_o),
    .result_valid_i (result_valid_o),
    .state_i        (u_ctrl.state_q),
    .div_start_i    (div_bus.start),
    .div_done_i     (div_bus.done)
);

// File: verification/ex_tb.sv
module ex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ex_pkg::*;

    localparam int DATA_W    = DATA_W_DEFAULT;
    localparam int MAX_VEC   = 64;
    localparam int COLS      = 6;
    localparam int TIMEOUT   = 4 * DATA_W + 20;
    localparam int INJECT_AT = 3;
    localparam logic [DATA_W-1:0] POISON = DATA_W'(32'hBAD0BAD0);

    logic              clk;
    logic              rst_n_i;
    logic              op_valid_i;
    aluop_t            aluop_i;
    logic [DATA_W-1:0] reg1_i;
    logic [DATA_W-1:0] reg2_i;
    logic              busy_o;
    logic              result_valid_o;
    logic [DATA_W-1:0] wdata_o;
    logic [DATA_W-1:0] hi_o;
    logic [DATA_W-1:0] lo_o;

    // op, reg1, reg2, wdata, hi, lo per vector
    logic [DATA_W-1:0] vec_mem [0:MAX_VEC*COLS-1];
    int                num_vec;
    int                check_cnt;
    int                error_cnt;
    int                timeout_cnt;
    int                assert_cnt;

    ex_top #(
        .DATA_W (DATA_W)
    ) DUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .op_valid_i     (op_valid_i),
        .aluop_i        (aluop_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .wdata_o        (wdata_o),
        .hi_o           (hi_o),
        .lo_o           (lo_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] expected);
        check_cnt++;
        if (got !== expected) begin
            error_cnt++;
            $display("ERROR at time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
        end
    endtask

    // strobe to result_valid_o in falling edges
    function automatic int expected_latency(aluop_t op);
        int lat;
        lat = 1;
        if (op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) begin
            lat = 2;
        end else if (op inside {OP_DIV, OP_DIVU}) begin
            lat = DATA_W + 2;
        end
        return lat;
    endfunction

    function automatic int count_vectors();
        int n;
        n = 0;
        while (n < MAX_VEC && vec_mem[n*COLS] != '1) begin
            n++;
        end
        return n;
    endfunction

    // starts and ends on a falling edge
    task automatic run_vector(input int idx, output bit timed_out);
        aluop_t op;
        int     base;
        int     cycles;
        int     busy_cycles;
        int     lat;
        bit     inject;
        base      = idx * COLS;
        op        = aluop_t'(vec_mem[base][4:0]);
        lat       = expected_latency(op);
        inject    = (lat > INJECT_AT + 1);
        timed_out = 1'b0;
        op_valid_i = 1'b1;
        aluop_i    = op;
        reg1_i     = vec_mem[base + 1];
        reg2_i     = vec_mem[base + 2];
        @(negedge clk);
        op_valid_i  = 1'b0;
        cycles      = 1;
        busy_cycles = 0;
        while (!result_valid_o && !timed_out) begin
            if (busy_o) begin
                busy_cycles++;
            end
            if (cycles >= TIMEOUT) begin
                timed_out = 1'b1;
            end else begin
                // a strobe while busy must be dropped
                if (inject && cycles == INJECT_AT) begin
                    op_valid_i = 1'b1;
                    aluop_i    = OP_OR;
                    reg1_i     = POISON;
                end else begin
                    op_valid_i = 1'b0;
                end
                @(negedge clk);
                cycles++;
            end
        end
        if (timed_out) begin
            $display("timeout: vector %0d (op %0d) got no result_valid_o within %0d cycles",
                     idx, op, TIMEOUT);
        end else begin
            check_value("wdata_o", wdata_o, vec_mem[base + 3]);
            check_value("hi_o", hi_o, vec_mem[base + 4]);
            check_value("lo_o", lo_o, vec_mem[base + 5]);
            check_value("result_valid_o latency", cycles, lat);
            check_value("busy_o high cycles", busy_cycles, lat - 1);
        end
    endtask

    initial begin
        bit timed_out;
        int idx;
        check_cnt   = 0;
        error_cnt   = 0;
        timeout_cnt = 0;
        assert_cnt  = 0;
        timed_out   = 1'b0;
        rst_n_i     = 1'b0;
        op_valid_i  = 1'b0;
        aluop_i     = OP_OR;
        reg1_i      = '0;
        reg2_i      = '0;
        for (int i = 0; i < MAX_VEC * COLS; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("verification/ex_tests.txt", vec_mem);
        num_vec = count_vectors();
        if (num_vec == 0) begin
            error_cnt++;
            $display("no test vectors could be read from verification/ex_tests.txt");
        end

        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_value("busy_o", DATA_W'(busy_o), '0);
        check_value("result_valid_o", DATA_W'(result_valid_o), '0);
        check_value("hi_o", hi_o, '0);
        check_value("lo_o", lo_o, '0);

        idx = 0;
        while (idx < num_vec && !timed_out) begin
            run_vector(idx, timed_out);
            idx++;
        end
        if (timed_out) begin
            timeout_cnt = 1;
        end
        repeat (2) @(negedge clk);

        assert_cnt = DUT.u_assert.idle_fail_cnt + DUT.u_assert.div_fail_cnt
                   + DUT.u_assert.busy_fail_cnt;
        $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 check_cnt, error_cnt, timeout_cnt, assert_cnt);
        if (error_cnt == 0 && timeout_cnt == 0 && assert_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end
endmodule

// File: verification/ex_tests.txt
// columns: op reg1 reg2 wdata hi lo, all hex
// hi and lo are the expected register contents after the operation
00 0F0F00FF 00F0F0F0 0FFFF0FF 00000000 00000000
01 0F0F00FF 00F0F0F0 000000F0 00000000 00000000
02 12345678 FFFF0000 EDCB5678 00000000 00000000
03 0000FFFF 00FF0000 FF000000 00000000 00000000
04 00000004 0000000F 000000F0 00000000 00000000
05 00000008 F0000000 00F00000 00000000 00000000
06 00000024 80000010 F8000001 00000000 00000000
07 FFFFFFFF 00000002 00000001 00000000 00000000
08 00000003 00000005 FFFFFFFE 00000000 00000000
09 FFFFFFFF 00000001 00000001 00000000 00000000
0A FFFFFFFF 00000001 00000000 00000000 00000000
0B 00000000 00000000 00000020 00000000 00000000
0B FFFFFFFF 00000000 00000000 00000000 00000000
0B 00010000 00000000 0000000F 00000000 00000000
0C FFFFFFFF 00000000 00000020 00000000 00000000
0C 00000000 00000000 00000000 00000000 00000000
0C FFF00000 00000000 0000000C 00000000 00000000
11 FFFFFFFD 00000007 FFFFFFEB 00000000 00000000
12 FFFFFFFE 00000003 00000000 FFFFFFFF FFFFFFFA
13 FFFFFFFE 00000003 00000000 00000002 FFFFFFFA
0F 11112222 00000000 00000000 11112222 FFFFFFFA
10 33334444 00000000 00000000 11112222 33334444
0D 00000000 00000000 11112222 11112222 33334444
0E 00000000 00000000 33334444 11112222 33334444
14 00000010 FFFFFFFF 00000000 11112222 33334434
15 80000000 00000004 00000000 11112224 33334434
16 FFFFFFFE 00000005 00000000 11112224 3333443E
17 00000002 40000000 00000000 11112223 B333443E
18 FFFFFFF9 00000002 00000000 FFFFFFFF FFFFFFFD
18 00000007 FFFFFFFE 00000000 00000001 FFFFFFFD
19 FFFFFFF9 00000002 00000000 00000001 7FFFFFFC
18 FFFFFFF9 00000000 00000000 FFFFFFF9 00000001
19 00000064 00000000 00000000 00000064 FFFFFFFF
0E 00000000 00000000 FFFFFFFF 00000064 FFFFFFFF
